/* hdl/opcap_pkg.sv */
// ==========================================================================
// Widths and the operand record shared by the operand-capture design.
// Register count and value width are fixed here. The number of write
// ports, entries and history stages is set by parameters at the top level.
// ==========================================================================

package opcap_pkg;

	// Physical register file size and the width of a register number
	localparam int NPREG = 32;
	localparam int PREG_W = 5;

	// Data value and flags widths
	localparam int VAL_W = 32;
	localparam int FLAGS_W = 4;

	// Marks an operand as holding its value
	localparam logic VAL = 1'b1;

	typedef logic [PREG_W-1:0] preg_t;
	typedef logic [VAL_W-1:0] value_t;

	// One source operand as it moves between the capture stages
	typedef struct packed {
		logic v;
		logic z;
		logic is_const;
		preg_t pRn;
		value_t val;
		logic [FLAGS_W-1:0] flags;
		logic pad;
	} operand_t;

	// Turns one write-port result into an operand record
	function automatic operand_t mk_oper(logic v, preg_t rn, value_t val,
		logic [FLAGS_W-1:0] flags);
		operand_t o;
		o = '0;
		o.v = v;
		o.pRn = rn;
		o.val = val;
		o.flags = flags;
		return o;
	endfunction

endpackage

/* hdl/wr_port_if.sv */
// ==========================================================================
// One register-file write port. A write is a single-cycle level on wr_v
// and is always accepted, there is no back-pressure.
// ==========================================================================

`timescale 1ns/1ps

interface wr_port_if;

	// Write strobe, target register, result value and result flags
	logic wr_v;
	opcap_pkg::preg_t wr_preg;
	opcap_pkg::value_t wr_val;
	logic [opcap_pkg::FLAGS_W-1:0] wr_flags;

	// The block producing results drives the port
	modport source (output wr_v, output wr_preg, output wr_val, output wr_flags);

	// Register file, history and bypass all listen to it
	modport sink (input wr_v, input wr_preg, input wr_val, input wr_flags);

endinterface

/* hdl/preg_file.sv */
// ==========================================================================
// Physical register file with one written bit per register.
// Reads are registered and data shows up one cycle after the address.
// A write is seen by reads only from the following edge onward.
// Same-cycle writes to one register resolve to the highest port.
// ==========================================================================

`timescale 1ns/1ps

module preg_file #(
	parameter int NENTRY = 3,
	parameter int NWR = 2
) (
	input logic clk_i,
	input logic rst_n_i,
	wr_port_if.sink wr [NWR],
	input opcap_pkg::preg_t rd_preg_i [NENTRY],
	output opcap_pkg::operand_t rd_oper_o [NENTRY]
);

	// Register values and flags as left by the last write to each register
	opcap_pkg::value_t regs [opcap_pkg::NPREG];
	logic [opcap_pkg::FLAGS_W-1:0] reg_flags [opcap_pkg::NPREG];

	// Set once a register has received a value since reset
	logic [opcap_pkg::NPREG-1:0] written;

	// Write ports gathered as operand records
	opcap_pkg::operand_t wp [NWR];

	for (genvar g = 0; g < NWR; g++) begin : g_wp
		assign wp[g] = opcap_pkg::mk_oper(wr[g].wr_v, wr[g].wr_preg, wr[g].wr_val,
			wr[g].wr_flags);
	end

	// Ports are applied in order so the last port naming a register wins
	always_ff @(posedge clk_i) begin
		for (int p = 0; p < NWR; p++) begin
			if (wp[p].v) begin
				regs[wp[p].pRn] <= wp[p].val;
				reg_flags[wp[p].pRn] <= wp[p].flags;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i)
			written <= '0;
		else begin
			for (int p = 0; p < NWR; p++) begin
				if (wp[p].v)
					written[wp[p].pRn] <= 1'b1;
			end
		end
	end

	// Registered read ports whose valid bit is the register's written bit
	always_ff @(posedge clk_i) begin
		for (int r = 0; r < NENTRY; r++) begin
			if (!rst_n_i)
				rd_oper_o[r].v <= 1'b0;
			else
				rd_oper_o[r] <= opcap_pkg::mk_oper(written[rd_preg_i[r]], rd_preg_i[r],
					regs[rd_preg_i[r]], reg_flags[rd_preg_i[r]]);
		end
	end

endmodule

/* hdl/wr_port_history.sv */
// ==========================================================================
// Short record of recent write-port results with stage 0 as the newest.
// It covers the cycles where a register read is still in flight and
// would return the value from before the write.
// ==========================================================================

`timescale 1ns/1ps

module wr_port_history #(
	parameter int NWR = 2,
	parameter int HIST_DEPTH = 3
) (
	input logic clk_i,
	input logic rst_n_i,
	wr_port_if.sink wr [NWR],
	output opcap_pkg::operand_t hist_o [HIST_DEPTH][NWR]
);

	opcap_pkg::operand_t wp [NWR];
	opcap_pkg::operand_t hist_q [HIST_DEPTH][NWR];

	// Each port recorded the way the register file would return it
	for (genvar g = 0; g < NWR; g++) begin : g_wp
		assign wp[g] = opcap_pkg::mk_oper(wr[g].wr_v, wr[g].wr_preg, wr[g].wr_val,
			wr[g].wr_flags);
	end

	// Stage 0 takes the current write ports at every edge
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			for (int s = 0; s < HIST_DEPTH; s++)
				for (int p = 0; p < NWR; p++)
					hist_q[s][p].v <= 1'b0;
		end
		else begin
			hist_q[0] <= wp;
			// Older stages move down by one each edge
			for (int s = 1; s < HIST_DEPTH; s++)
				hist_q[s] <= hist_q[s-1];
		end
	end

	assign hist_o = hist_q;

endmodule

/* hdl/operand_validate.sv */
// ==========================================================================
// Combinational operand merge. Order of priority, lowest first, is
// register read, then history (newest stage last), then the bypass.
// Operands that are already valid go through untouched.
// ==========================================================================

`timescale 1ns/1ps

module operand_validate #(
	parameter int NENTRY = 3,
	parameter int NWR = 2,
	parameter int HIST_DEPTH = 3,
	parameter bit BYPASS_EN = 1'b1
) (
	input opcap_pkg::operand_t oper_i [NENTRY],
	input opcap_pkg::operand_t rd_oper_i [NENTRY],
	input opcap_pkg::operand_t hist_i [HIST_DEPTH][NWR],
	wr_port_if.sink wr [NWR],
	output opcap_pkg::operand_t oper_o [NENTRY]
);

	// Merge result before the bypass is applied
	opcap_pkg::operand_t oper_m [NENTRY];

	// An operand still waiting on a register result
	logic [NENTRY-1:0] need;

	always_comb begin
		for (int nn = 0; nn < NENTRY; nn++) begin
			oper_m[nn] = oper_i[nn];
			need[nn] = !oper_i[nn].v && !oper_i[nn].z && !oper_i[nn].is_const;
			if (!oper_i[nn].v) begin
				oper_m[nn].val = '0;
				oper_m[nn].flags = '0;
				// Hard zero keeps the cleared value
				if (oper_i[nn].z)
					oper_m[nn].v = opcap_pkg::VAL;
				else if (oper_i[nn].is_const) begin
					oper_m[nn].v = opcap_pkg::VAL;
					oper_m[nn].val = oper_i[nn].val;
				end
			end
			// Any read port returning this register will do
			for (int jj = 0; jj < NENTRY; jj++) begin
				if (need[nn] && rd_oper_i[jj].v && rd_oper_i[jj].pRn == oper_i[nn].pRn)
					oper_m[nn] = rd_oper_i[jj];
			end
			// Walk from the oldest stage so the newest result is the one kept
			for (int ss = HIST_DEPTH - 1; ss >= 0; ss--) begin
				for (int pp = 0; pp < NWR; pp++) begin
					if (need[nn] && hist_i[ss][pp].v && hist_i[ss][pp].pRn == oper_i[nn].pRn)
						oper_m[nn] = hist_i[ss][pp];
				end
			end
		end
	end

	// ======================================================================
	// Same-cycle bypass from the write ports
	// ======================================================================
	if (BYPASS_EN) begin : g_byp
		opcap_pkg::operand_t byp [NWR];

		for (genvar g = 0; g < NWR; g++) begin : g_port
			assign byp[g] = opcap_pkg::mk_oper(wr[g].wr_v, wr[g].wr_preg, wr[g].wr_val,
				wr[g].wr_flags);
		end

		always_comb begin
			for (int nn = 0; nn < NENTRY; nn++) begin
				oper_o[nn] = oper_m[nn];
				for (int pp = 0; pp < NWR; pp++) begin
					if (need[nn] && byp[pp].v && byp[pp].pRn == oper_i[nn].pRn)
						oper_o[nn] = byp[pp];
				end
			end
		end
	end
	else begin : g_nobyp
		assign oper_o = oper_m;
	end

endmodule

/* hdl/operand_capture.sv */
// ==========================================================================
// Capture entry for one instruction's source operands.
// A load replaces the entry at once and drops ready_o. Ready follows two
// edges after all operands validate, since it is taken from held state.
// ==========================================================================

`timescale 1ns/1ps

module operand_capture #(
	parameter int NENTRY = 3
) (
	input logic clk_i,
	input logic rst_n_i,
	input logic load_i,
	input opcap_pkg::preg_t opnd_preg_i [NENTRY],
	input logic [NENTRY-1:0] opnd_z_i,
	input logic [NENTRY-1:0] opnd_const_i,
	input opcap_pkg::value_t opnd_imm_i [NENTRY],
	input opcap_pkg::operand_t oper_i [NENTRY],
	output opcap_pkg::operand_t oper_o [NENTRY],
	output opcap_pkg::preg_t rd_preg_o [NENTRY],
	output logic ready_o,
	output opcap_pkg::value_t oper_val_o [NENTRY]
);

	opcap_pkg::operand_t oper_q [NENTRY];

	// Collected valid bits of the held operands
	logic [NENTRY-1:0] held_v;

	// A load builds new operand records and every other edge takes the
	// validated operands from the merge
	always_ff @(posedge clk_i) begin
		for (int i = 0; i < NENTRY; i++) begin
			if (!rst_n_i) begin
				oper_q[i].v <= 1'b0;
				oper_q[i].z <= 1'b0;
				oper_q[i].is_const <= 1'b0;
			end
			else if (load_i) begin
				// New operands always start out waiting
				oper_q[i] <= '0;
				oper_q[i].z <= opnd_z_i[i];
				oper_q[i].is_const <= opnd_const_i[i];
				oper_q[i].pRn <= opnd_preg_i[i];
				oper_q[i].val <= opnd_imm_i[i];
			end
			else
				oper_q[i] <= oper_i[i];
		end
	end

	for (genvar g = 0; g < NENTRY; g++) begin : g_out
		assign held_v[g] = oper_q[g].v;
		assign rd_preg_o[g] = oper_q[g].pRn;
		assign oper_val_o[g] = oper_q[g].val;
	end

	assign oper_o = oper_q;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i || load_i)
			ready_o <= 1'b0;
		else
			ready_o <= &held_v;
	end

endmodule

/* hdl/opcap_top.sv */
// ==========================================================================
// Operand-capture stage with a single capture entry.
// Write flags are tied to zero. Port NWR-1 wins when both ports write
// the same register in one cycle. Bypass is set with BYPASS_EN.
// ==========================================================================

`timescale 1ns/1ps

module opcap_top #(
	parameter int NENTRY = 3,
	parameter int NWR = 2,
	parameter int HIST_DEPTH = 3,
	parameter bit BYPASS_EN = 1'b1
) (
	input logic clk_i,
	input logic rst_n_i,
	input logic load_i,
	input opcap_pkg::preg_t opnd_preg_i [NENTRY],
	input logic [NENTRY-1:0] opnd_z_i,
	input logic [NENTRY-1:0] opnd_const_i,
	input opcap_pkg::value_t opnd_imm_i [NENTRY],
	input logic [NWR-1:0] wr_v_i,
	input opcap_pkg::preg_t wr_preg_i [NWR],
	input opcap_pkg::value_t wr_val_i [NWR],
	output logic ready_o,
	output opcap_pkg::value_t oper_val_o [NENTRY]
);

	// Held operands, register reads, history and merged result
	opcap_pkg::operand_t cap_oper [NENTRY];
	opcap_pkg::operand_t rd_oper [NENTRY];
	opcap_pkg::operand_t hist [HIST_DEPTH][NWR];
	opcap_pkg::operand_t val_oper [NENTRY];
	opcap_pkg::preg_t rd_preg [NENTRY];

	wr_port_if wr_bus [NWR] ();

	// The plain write ports feed the shared write buses
	for (genvar g = 0; g < NWR; g++) begin : g_wr
		assign wr_bus[g].wr_v = wr_v_i[g];
		assign wr_bus[g].wr_preg = wr_preg_i[g];
		assign wr_bus[g].wr_val = wr_val_i[g];
		assign wr_bus[g].wr_flags = '0;
	end

	preg_file #(.NENTRY(NENTRY), .NWR(NWR)) u_rf (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .wr(wr_bus),
		.rd_preg_i(rd_preg), .rd_oper_o(rd_oper)
	);

	wr_port_history #(.NWR(NWR), .HIST_DEPTH(HIST_DEPTH)) u_hist (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .wr(wr_bus), .hist_o(hist)
	);

	operand_validate #(
		.NENTRY(NENTRY), .NWR(NWR), .HIST_DEPTH(HIST_DEPTH), .BYPASS_EN(BYPASS_EN)
	) u_val (
		.oper_i(cap_oper), .rd_oper_i(rd_oper), .hist_i(hist), .wr(wr_bus),
		.oper_o(val_oper)
	);

	operand_capture #(.NENTRY(NENTRY)) u_cap (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .load_i(load_i),
		.opnd_preg_i(opnd_preg_i), .opnd_z_i(opnd_z_i), .opnd_const_i(opnd_const_i),
		.opnd_imm_i(opnd_imm_i), .oper_i(val_oper), .oper_o(cap_oper),
		.rd_preg_o(rd_preg), .ready_o(ready_o), .oper_val_o(oper_val_o)
	);

endmodule

/* tb/tb_opcap.sv */
// ==========================================================================
// Self-checking testbench for the operand-capture top level.
// Commands come from tb/opcap_tests.txt, run from the project root.
// Expected values come from a reference register model and the data file.
// ==========================================================================

`timescale 1ns/1ps

module tb_opcap;

	localparam int NENTRY = 3;
	localparam int NWR = 2;

	logic clk_i;
	logic rst_n_i;
	logic load_i;
	opcap_pkg::preg_t opnd_preg_i [NENTRY];
	logic [NENTRY-1:0] opnd_z_i;
	logic [NENTRY-1:0] opnd_const_i;
	opcap_pkg::value_t opnd_imm_i [NENTRY];
	logic [NWR-1:0] wr_v_i;
	opcap_pkg::preg_t wr_preg_i [NWR];
	opcap_pkg::value_t wr_val_i [NWR];
	logic ready_o;
	opcap_pkg::value_t oper_val_o [NENTRY];

	// Inputs staged for the next cycle, kind 0 is a register, 1 a constant, 2 zero
	logic ld_s;
	logic [1:0] kind_s [NENTRY];
	logic [31:0] x_s [NENTRY];
	logic [NWR-1:0] wv_s;
	opcap_pkg::preg_t wp_s [NWR];
	opcap_pkg::value_t wd_s [NWR];

	// Reference register values and the operands of the loaded entry
	opcap_pkg::value_t ref_regs [opcap_pkg::NPREG];
	logic [1:0] kind_q [NENTRY];
	logic [31:0] x_q [NENTRY];

	int seed;
	int errors;
	int checks;

	opcap_top #(.NENTRY(NENTRY), .NWR(NWR)) dut0 (.*);

	initial begin
		clk_i = 1'b0;
		forever #2 clk_i = ~clk_i;
	end

	// Drives the staged inputs after a rising edge, unused fields get random fill
	task automatic tick();
		logic [31:0] rnd;
		@(posedge clk_i);
		load_i <= ld_s;
		for (int i = 0; i < NENTRY; i++) begin
			rnd = $random(seed);
			opnd_preg_i[i] <= x_s[i][4:0];
			opnd_z_i[i] <= (kind_s[i] == 2'd2);
			opnd_const_i[i] <= (kind_s[i] == 2'd1);
			opnd_imm_i[i] <= (kind_s[i] == 2'd1) ? x_s[i] : rnd;
			if (ld_s) begin
				kind_q[i] = kind_s[i];
				x_q[i] = x_s[i];
			end
		end
		// Port order matters, the higher port wins on the same register
		for (int p = 0; p < NWR; p++) begin
			rnd = $random(seed);
			wr_v_i[p] <= wv_s[p];
			wr_preg_i[p] <= wv_s[p] ? wp_s[p] : rnd[4:0];
			wr_val_i[p] <= wv_s[p] ? wd_s[p] : rnd;
			if (wv_s[p])
				ref_regs[wp_s[p]] = wd_s[p];
		end
		ld_s = 1'b0;
		wv_s = '0;
	endtask

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// Value an operand must end with, by its kind
	function automatic logic [31:0] expect_val(input logic [1:0] kind, input logic [31:0] x);
		if (kind == 2'd2)
			return '0;
		else if (kind == 2'd1)
			return x;
		return ref_regs[x[4:0]];
	endfunction

	// The first tick only drives staged inputs, ready_o is checked after later edges
	task automatic wait_ready(input logic [31:0] e [6]);
		int n;
		tick();
		n = 0;
		do begin
			tick();
			@(negedge clk_i);
			n++;
		end while (!ready_o && n < 50);
		if (!ready_o) begin
			errors++;
			$display("Timed out after %0d cycles waiting for ready_o", n);
		end
		else begin
			for (int i = 0; i < NENTRY; i++) begin
				check_eq($sformatf("oper_val_o[%0d]", i), oper_val_o[i],
					expect_val(kind_q[i], x_q[i]));
				check_eq($sformatf("oper_val_o[%0d]", i), oper_val_o[i], e[i]);
			end
		end
	endtask

	// An operand that never gets its register must keep ready_o low
	task automatic hold_low(input int n);
		tick();
		for (int k = 0; k < n; k++) begin
			tick();
			@(negedge clk_i);
			check_eq("ready_o", {31'b0, ready_o}, 32'h0);
		end
	endtask

	initial begin
		int fd;
		int nlines;
		string line;
		logic [7:0] cmd;
		logic [31:0] f [6];
		seed = 32'h7cfcec21;
		errors = 0;
		checks = 0;
		rst_n_i = 1'b0;
		load_i = 1'b0;
		opnd_z_i = '0;
		opnd_const_i = '0;
		wr_v_i = '0;
		ld_s = 1'b0;
		wv_s = '0;
		for (int i = 0; i < NENTRY; i++) begin
			opnd_preg_i[i] = '0;
			opnd_imm_i[i] = '0;
			kind_s[i] = 2'd2;
			x_s[i] = '0;
		end
		for (int p = 0; p < NWR; p++) begin
			wr_preg_i[p] = '0;
			wr_val_i[p] = '0;
			wp_s[p] = '0;
			wd_s[p] = '0;
		end
		repeat (3) @(posedge clk_i);
		rst_n_i <= 1'b1;

		fd = $fopen("tb/opcap_tests.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Could not open the tests file tb/opcap_tests.txt");
		end
		else begin
			nlines = 0;
			while (!$feof(fd) && nlines < 1000) begin
				nlines++;
				line = "";
				void'($fgets(line, fd));
				for (int k = 0; k < 6; k++)
					f[k] = '0;
				if (line.len() > 0) begin
					cmd = line.getc(0);
					void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h %h",
						f[0], f[1], f[2], f[3], f[4], f[5]));
					case (cmd)
						"W": begin
							wv_s[f[0][0]] = 1'b1;
							wp_s[f[0][0]] = f[1][4:0];
							wd_s[f[0][0]] = f[2];
						end
						"L": begin
							ld_s = 1'b1;
							for (int i = 0; i < NENTRY; i++) begin
								kind_s[i] = f[2*i][1:0];
								x_s[i] = f[2*i+1];
							end
						end
						"R": wait_ready(f);
						"I": repeat (f[0]) tick();
						"H": hold_low(f[0]);
						"#", "\n", " ": ;
						default: begin
							errors++;
							$display("Unknown command on line %0d of the tests file", nlines);
						end
					endcase
				end
			end
			$fclose(fd);
		end

		tick();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* tb/opcap_tests.txt */
# W port reg val | L kind0 x0 kind1 x1 kind2 x2 (kind 0 reg, 1 const, 2 zero) | R exp0 exp1 exp2
# I n idles n cycles | H n expects ready_o low for n cycles; all numbers in hex
L 2 0 1 1234abcd 2 0
R 0 1234abcd 0
W 0 3 aaaa0003
W 1 9 bbbb0009
I 3
L 0 3 0 9 1 55
R aaaa0003 bbbb0009 55
L 0 c 0 d 2 0
I 1
W 0 c 0000c0c0
I 1
W 1 d 0000d0d0
R 0000c0c0 0000d0d0 0
W 0 5 11111111
W 1 5 22222222
I 3
L 0 5 2 0 1 7
R 22222222 0 7
L 0 1f 1 8 2 0
H 32
L 1 77 0 5 0 3
R 77 22222222 aaaa0003

/* build.f */
hdl/opcap_pkg.sv
hdl/wr_port_if.sv
hdl/preg_file.sv
hdl/wr_port_history.sv
hdl/operand_validate.sv
hdl/operand_capture.sv
hdl/opcap_top.sv
tb/tb_opcap.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and searches the log for failure.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --top-module tb_opcap -f build.f -Mdir obj_dir -o sim_opcap
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_opcap > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
	exit 1
fi
exit 0
